/* dv/lpif_link_tb.sv */
/*
 * lpif link testbench
 * random flits through loopback, gen1, hold and the external path,
 * checked against a packing model and register reads
 */
`timescale 1ns/10ps

module lpif_link_tb
  import lpif_link_pkg::*;
();

  logic                     clk;
  logic                     reset;
  logic [lpif_state_w-1:0]  dstrm_state;
  logic [lpif_protid_w-1:0] dstrm_protid;
  logic [lpif_data_w-1:0]   dstrm_data;
  logic                     dstrm_dvalid;
  logic [lpif_crc_w-1:0]    dstrm_crc;
  logic                     dstrm_crc_valid;
  logic                     dstrm_valid;
  logic [lpif_state_w-1:0]  ustrm_state;
  logic [lpif_protid_w-1:0] ustrm_protid;
  logic [lpif_data_w-1:0]   ustrm_data;
  logic                     ustrm_dvalid;
  logic [lpif_crc_w-1:0]    ustrm_crc;
  logic                     ustrm_crc_valid;
  logic                     ustrm_valid;
  logic [lpif_word_w-1:0]   link_tx_data;
  logic                     link_tx_valid;
  logic                     link_hold;
  logic [lpif_word_w-1:0]   link_rx_data;
  logic                     link_rx_valid;
  logic                     cfg_wr;
  logic [cfg_addr_w-1:0]    cfg_addr;
  logic [cfg_data_w-1:0]    cfg_wdata;
  logic [cfg_data_w-1:0]    cfg_rdata;

  // expected words in order for each direction
  logic [lpif_word_w-1:0] tx_q [$];
  logic [lpif_word_w-1:0] rx_q [$];
  logic [lpif_word_w-1:0] lb_word;
  logic [lpif_word_w-1:0] ext_word;
  logic [lpif_word_w-1:0] rx_exp;
  logic [lpif_word_w-1:0] ustrm_word;
  logic                   lb_mode;
  logic                   gen2_cfg;
  logic                   lat_chk;
  logic                   ext_chk;
  logic [31:0]            lcg = 32'd62486;
  int                     tx_seen = 0;
  int                     rx_seen = 0;
  int                     tx_before;
  lpif_state_e            legal_states [9] = '{st_reset, st_active, st_active_pmnak, st_l1,
                                              st_l2, st_linkreset, st_linkerror, st_retrain,
                                              st_disabled};

  lpif_link_top i_lpif_link_top (.*);

  always #10 clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg = lcg * 32'd1664525 + 32'd1013904223;
    return lcg;
  endfunction

  // reference packing where the upper data half only travels in gen2
  function automatic logic [lpif_word_w-1:0] pack_word(
    input logic [lpif_state_w-1:0]  st,
    input logic [lpif_protid_w-1:0] pid,
    input logic [lpif_data_w-1:0]   d,
    input logic                     dv,
    input logic [lpif_crc_w-1:0]    crc,
    input logic                     cv,
    input logic                     gen2
  );
    logic [lpif_word_w-1:0] w;
    w = '0;
    w[state_lsb +: lpif_state_w]   = st;
    w[protid_lsb +: lpif_protid_w] = pid;
    w[data_lsb +: lpif_half_w]     = d[lpif_half_w-1:0];
    if (gen2) begin
      w[data_lsb + lpif_half_w +: lpif_half_w] = d[lpif_data_w-1:lpif_half_w];
    end
    w[dvalid_bit]               = dv;
    w[crc_lsb +: lpif_crc_w]    = crc;
    w[crc_valid_bit]            = cv;
    w[valid_bit]                = 1'b1;
    return w;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // one random flit on the downstream port and queued if the link should carry it
  task automatic drive_flit(input logic expect_word);
    logic [lpif_data_w-1:0] d;
    logic [31:0]            r;
    lpif_state_e            st;
    d  = {next_rand(), next_rand(), next_rand(), next_rand()};
    r  = next_rand();
    st = legal_states[r[31:16] % 9];
    @(posedge clk);
    dstrm_state     <= st;
    dstrm_protid    <= r[9:8];
    dstrm_data      <= d;
    dstrm_dvalid    <= r[4];
    dstrm_crc       <= r[15:12];
    dstrm_crc_valid <= r[5];
    dstrm_valid     <= 1'b1;
    if (expect_word) begin
      tx_q.push_back(pack_word(st, r[9:8], d, r[4], r[15:12], r[5], gen2_cfg));
    end
  endtask

  // full word on the receive port and expected back under the current data mask
  task automatic drive_rx_word();
    logic [lpif_word_w-1:0] w;
    logic [lpif_data_w-1:0] d;
    logic [31:0]            r;
    r = next_rand();
    d = {next_rand(), next_rand(), next_rand(), next_rand()};
    w = pack_word(r[3:0], r[9:8], d, r[4], r[15:12], r[5], 1'b1);
    rx_q.push_back(pack_word(r[3:0], r[9:8], d, r[4], r[15:12], r[5], gen2_cfg));
    @(posedge clk);
    link_rx_data  <= w;
    link_rx_valid <= 1'b1;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    dstrm_valid   <= 1'b0;
    link_rx_valid <= 1'b0;
  endtask

  task automatic write_reg(input cfg_reg_e addr, input logic [31:0] data);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wr    <= 1'b0;
  endtask

  // rdata is combinational so look at it mid cycle
  task automatic check_reg(input cfg_reg_e addr, input logic [31:0] exp, input string name);
    @(posedge clk);
    cfg_addr <= addr;
    @(negedge clk);
    assert (cfg_rdata == exp)
      else stop_run($sformatf("Fail %s expected %h got %h", name, exp, cfg_rdata));
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while ((tx_q.size() != 0 || rx_q.size() != 0 || link_tx_valid || ustrm_valid)
           && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (n >= limit) begin
      stop_run("timed out waiting for the link to drain");
    end
  endtask

  //////////////////////////////
  // monitors and checks
  //////////////////////////////

  // every word leaving on the link must be the next one queued
  always @(posedge clk) begin
    logic [lpif_word_w-1:0] w;
    if (!reset && link_tx_valid) begin
      if (tx_q.size() == 0) begin
        stop_run("a word left on link_tx_data that was never sent");
      end else begin
        w = tx_q.pop_front();
        tx_seen++;
        lb_word <= w;
        assert (link_tx_data == w)
          else stop_run($sformatf("Fail link_tx_data expected %h got %h", w, link_tx_data));
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && !lb_mode && link_rx_valid) begin
      if (rx_q.size() == 0) begin
        stop_run("link_rx_valid seen with no word queued");
      end else begin
        ext_word <= rx_q.pop_front();
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && ustrm_valid) begin
      rx_seen++;
    end
  end

  assign rx_exp     = lb_mode ? lb_word : ext_word;
  assign ustrm_word = pack_word(ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                                ustrm_crc, ustrm_crc_valid, 1'b1);

  a_rx_word : assert property (@(posedge clk) disable iff (reset)
    ustrm_valid |-> ustrm_word == rx_exp)
    else stop_run($sformatf("Fail ustrm_word expected %h got %h",
                            $sampled(rx_exp), $sampled(ustrm_word)));

  // loopback valid leaves the packer two edges on and is seen at the third sample
  a_lb_latency : assert property (@(posedge clk) disable iff (reset)
    lat_chk |-> ustrm_valid == $past(dstrm_valid, 3))
    else stop_run($sformatf("Fail ustrm_valid expected %h got %h",
                            !$sampled(ustrm_valid), $sampled(ustrm_valid)));

  a_ext_latency : assert property (@(posedge clk) disable iff (reset)
    ext_chk |-> ustrm_valid == $past(link_rx_valid))
    else stop_run($sformatf("Fail ustrm_valid expected %h got %h",
                            !$sampled(ustrm_valid), $sampled(ustrm_valid)));

  a_hold_quiet : assert property (@(posedge clk) disable iff (reset)
    $past(link_hold) |-> !link_tx_valid)
    else stop_run($sformatf("Fail link_tx_valid expected %h got %h", 1'b0, 1'b1));

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    dstrm_state = '0;
    dstrm_protid = '0;
    dstrm_data = '0;
    dstrm_dvalid = 1'b0;
    dstrm_crc = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid = 1'b0;
    link_hold = 1'b0;
    link_rx_data = '0;
    link_rx_valid = 1'b0;
    cfg_wr = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    lb_mode = 1'b0;
    gen2_cfg = 1'b1;
    lat_chk = 1'b0;
    ext_chk = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // out of reset
    @(negedge clk);
    assert (!link_tx_valid && !ustrm_valid)
      else stop_run("link_tx_valid or ustrm_valid high after reset");
    check_reg(reg_ctrl, 32'd1, "reg_ctrl");

    // gen2 loopback with some flits back to back
    write_reg(reg_ctrl, 32'd3);
    lb_mode <= 1'b1;
    lat_chk <= 1'b1;
    repeat (24) begin
      drive_flit(1'b1);
      if (next_rand() % 3 == 0) begin
        idle_cycle();
      end
    end
    idle_cycle();
    wait_idle(40);

    // gen1 loopback drops the upper data half
    write_reg(reg_ctrl, 32'd2);
    gen2_cfg = 1'b0;
    repeat (16) begin
      drive_flit(1'b1);
      if (next_rand() % 2 == 0) begin
        idle_cycle();
      end
    end
    idle_cycle();
    wait_idle(40);
    lat_chk <= 1'b0;

    // hold the link so the ninth push overflows and is lost
    write_reg(reg_ctrl, 32'd1);
    lb_mode  <= 1'b0;
    gen2_cfg = 1'b1;
    ext_chk  <= 1'b1;
    link_hold <= 1'b1;
    repeat (8) drive_flit(1'b1);
    drive_flit(1'b0);
    idle_cycle();
    repeat (3) idle_cycle();
    check_reg(reg_status, 32'd1, "reg_status");
    tx_before = tx_seen;
    @(posedge clk);
    link_hold <= 1'b0;
    wait_idle(40);
    repeat (4) idle_cycle();
    assert (tx_seen - tx_before == 8)
      else stop_run($sformatf("Fail link_tx_valid count expected %h got %h",
                              8, tx_seen - tx_before));
    write_reg(reg_status, 32'd1);
    check_reg(reg_status, 32'd0, "reg_status");

    // external path both ways
    repeat (6) begin
      drive_flit(1'b1);
      idle_cycle();
    end
    repeat (8) begin
      drive_rx_word();
      if (next_rand() % 2 == 0) begin
        idle_cycle();
      end
    end
    idle_cycle();
    wait_idle(40);

    // gen1 on the external path clears the upper half of received data
    write_reg(reg_ctrl, 32'd0);
    gen2_cfg = 1'b0;
    repeat (4) begin
      drive_rx_word();
      idle_cycle();
    end
    wait_idle(40);

    // counters against the testbench tallies and then cleared
    check_reg(reg_tx_count, 32'(tx_seen[cnt_w-1:0]), "reg_tx_count");
    check_reg(reg_rx_count, 32'(rx_seen[cnt_w-1:0]), "reg_rx_count");
    write_reg(reg_tx_count, 32'd0);
    write_reg(reg_rx_count, 32'hffff);
    check_reg(reg_tx_count, 32'd0, "reg_tx_count");
    check_reg(reg_rx_count, 32'd0, "reg_rx_count");
    ext_chk <= 1'b0;

    $display("All tests passed");
    $finish;
  end

endmodule

/* logic/lpif_flit_packer.sv */
/*
 * lpif flit packer
 * packs downstream flit fields into a 141-bit link word and unpacks
 * received words into registered upstream fields, with gen1 masking
 */
`timescale 1ns/10ps

module lpif_flit_packer
  import lpif_link_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     gen2_mode,
  // downstream channel
  input  logic [lpif_state_w-1:0]  dstrm_state,
  input  logic [lpif_protid_w-1:0] dstrm_protid,
  input  logic [lpif_data_w-1:0]   dstrm_data,
  input  logic                     dstrm_dvalid,
  input  logic [lpif_crc_w-1:0]    dstrm_crc,
  input  logic                     dstrm_crc_valid,
  input  logic                     dstrm_valid,
  output logic [lpif_word_w-1:0]   tx_word,
  // receive side
  input  logic [lpif_word_w-1:0]   rx_word,
  input  logic                     rx_valid,
  // upstream channel
  output logic [lpif_state_w-1:0]  ustrm_state,
  output logic [lpif_protid_w-1:0] ustrm_protid,
  output logic [lpif_data_w-1:0]   ustrm_data,
  output logic                     ustrm_dvalid,
  output logic [lpif_crc_w-1:0]    ustrm_crc,
  output logic                     ustrm_crc_valid,
  output logic                     ustrm_valid
);

  logic [lpif_data_w-1:0] tx_data;
  logic [lpif_data_w-1:0] rx_data;

  ///////////////////////////////
  // transmit packing
  ///////////////////////////////

  // gen1 only carries the lower half, upper half goes out as zero
  assign tx_data = gen2_mode ? dstrm_data :
                   {{(lpif_data_w-lpif_half_w){1'b0}}, dstrm_data[lpif_half_w-1:0]};

  assign tx_word[state_lsb +: lpif_state_w]   = dstrm_state;
  assign tx_word[protid_lsb +: lpif_protid_w] = dstrm_protid;
  assign tx_word[data_lsb +: lpif_data_w]     = tx_data;
  assign tx_word[dvalid_bit]                  = dstrm_dvalid;
  assign tx_word[crc_lsb +: lpif_crc_w]       = dstrm_crc;
  assign tx_word[crc_valid_bit]               = dstrm_crc_valid;
  assign tx_word[valid_bit]                   = dstrm_valid;

  ///////////////////////////////
  // receive unpacking
  ///////////////////////////////

  // same masking on the way back in
  assign rx_data = gen2_mode ? rx_word[data_lsb +: lpif_data_w] :
                   {{(lpif_data_w-lpif_half_w){1'b0}},
                    rx_word[data_lsb +: lpif_half_w]};

  // valid is a one cycle pulse behind rx_valid
  always_ff @(posedge clk) begin
    if (reset) begin
      ustrm_valid <= 1'b0;
    end else begin
      ustrm_valid <= rx_valid;
    end
  end

  // payload fields hold until the next received word
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      ustrm_state     <= rx_word[state_lsb +: lpif_state_w];
      ustrm_protid    <= rx_word[protid_lsb +: lpif_protid_w];
      ustrm_data      <= rx_data;
      ustrm_dvalid    <= rx_word[dvalid_bit];
      ustrm_crc       <= rx_word[crc_lsb +: lpif_crc_w];
      ustrm_crc_valid <= rx_word[crc_valid_bit];
    end
  end

  // adapter must only send flits carrying a defined link state
  a_legal_state : assert property (@(posedge clk) disable iff (reset)
    dstrm_valid |-> dstrm_state inside {st_reset, st_active, st_active_pmnak, st_l1,
                                        st_l2, st_linkreset, st_linkerror, st_retrain,
                                        st_disabled});

endmodule

/* logic/lpif_link_pkg.sv */
/*
 * lpif link package
 * widths, link word field offsets, fifo sizing and the shared enums
 */
package lpif_link_pkg;

  // flit field widths
  localparam int lpif_word_w   = 141;
  localparam int lpif_data_w   = 128;
  localparam int lpif_half_w   = 64;
  localparam int lpif_state_w  = 4;
  localparam int lpif_protid_w = 2;
  localparam int lpif_crc_w    = 4;

  // field placement inside one link word
  localparam int state_lsb     = 0;
  localparam int protid_lsb    = 4;
  localparam int data_lsb      = 6;
  localparam int dvalid_bit    = 134;
  localparam int crc_lsb       = 135;
  localparam int crc_valid_bit = 139;
  localparam int valid_bit     = 140;

  // transmit fifo sizing
  localparam int fifo_depth  = 8;
  localparam int fifo_ptr_w  = $clog2(fifo_depth);
  localparam int fifo_cnt_w  = $clog2(fifo_depth + 1);

  // register port and counters
  localparam int cfg_addr_w = 2;
  localparam int cfg_data_w = 32;
  localparam int cnt_w      = 16;

  typedef enum logic [cfg_addr_w-1:0] {
    reg_ctrl     = 2'd0,
    reg_tx_count = 2'd1,
    reg_rx_count = 2'd2,
    reg_status   = 2'd3
  } cfg_reg_e;

  // lpif link state encodings
  typedef enum logic [lpif_state_w-1:0] {
    st_reset        = 4'b0000,
    st_active       = 4'b0001,
    st_active_pmnak = 4'b0011,
    st_l1           = 4'b0100,
    st_l2           = 4'b1000,
    st_linkreset    = 4'b1001,
    st_linkerror    = 4'b1010,
    st_retrain      = 4'b1011,
    st_disabled     = 4'b1100
  } lpif_state_e;

endpackage

/* logic/lpif_link_regs.sv */
/*
 * lpif link register block
 * mode control, flit counters and the sticky fifo overflow flag
 */
`timescale 1ns/10ps

module lpif_link_regs
  import lpif_link_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cfg_wr,
  input  logic [cfg_addr_w-1:0] cfg_addr,
  input  logic [cfg_data_w-1:0] cfg_wdata,
  output logic [cfg_data_w-1:0] cfg_rdata,
  input  logic                  tx_flit,
  input  logic                  rx_flit,
  input  logic                  overflow,
  output logic                  gen2_mode,
  output logic                  loopback
);

  logic [cnt_w-1:0] tx_cnt;
  logic [cnt_w-1:0] rx_cnt;
  logic             ovf_flag;
  logic             wr_ctrl;
  logic             wr_tx_cnt;
  logic             wr_rx_cnt;
  logic             clr_ovf;

  // write decode
  assign wr_ctrl   = cfg_wr && (cfg_addr == reg_ctrl);
  assign wr_tx_cnt = cfg_wr && (cfg_addr == reg_tx_count);
  assign wr_rx_cnt = cfg_wr && (cfg_addr == reg_rx_count);
  assign clr_ovf   = cfg_wr && (cfg_addr == reg_status) && cfg_wdata[0];

  ///////////////////////////////
  // control register
  ///////////////////////////////

  // comes out of reset in gen2 with loopback off
  always_ff @(posedge clk) begin
    if (reset) begin
      gen2_mode <= 1'b1;
      loopback  <= 1'b0;
    end else if (wr_ctrl) begin
      gen2_mode <= cfg_wdata[0];
      loopback  <= cfg_wdata[1];
    end
  end

  ///////////////////////////////
  // counters and status
  ///////////////////////////////

  // counters wrap; any write to the address clears
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_cnt <= '0;
      rx_cnt <= '0;
    end else begin
      if (wr_tx_cnt) begin
        tx_cnt <= '0;
      end else if (tx_flit) begin
        tx_cnt <= tx_cnt + 1'b1;
      end
      if (wr_rx_cnt) begin
        rx_cnt <= '0;
      end else if (rx_flit) begin
        rx_cnt <= rx_cnt + 1'b1;
      end
    end
  end

  // set beats clear when both land together
  always_ff @(posedge clk) begin
    if (reset) begin
      ovf_flag <= 1'b0;
    end else if (overflow) begin
      ovf_flag <= 1'b1;
    end else if (clr_ovf) begin
      ovf_flag <= 1'b0;
    end
  end

  // read mux
  always_comb begin
    cfg_rdata = '0;
    case (cfg_reg_e'(cfg_addr))
      reg_ctrl:     cfg_rdata[1:0] = {loopback, gen2_mode};
      reg_tx_count: cfg_rdata[cnt_w-1:0] = tx_cnt;
      reg_rx_count: cfg_rdata[cnt_w-1:0] = rx_cnt;
      reg_status:   cfg_rdata[0] = ovf_flag;
      default:      cfg_rdata = '0;
    endcase
  end

  a_ovf_sticky : assert property (@(posedge clk) disable iff (reset)
    $fell(ovf_flag) |-> $past(clr_ovf));

endmodule

/* logic/lpif_link_top.sv */
/*
 * lpif link top
 * packer, transmit fifo, loopback receive mux and register block
 */
`timescale 1ns/10ps

module lpif_link_top
  import lpif_link_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  // downstream channel from the adapter
  input  logic [lpif_state_w-1:0]  dstrm_state,
  input  logic [lpif_protid_w-1:0] dstrm_protid,
  input  logic [lpif_data_w-1:0]   dstrm_data,
  input  logic                     dstrm_dvalid,
  input  logic [lpif_crc_w-1:0]    dstrm_crc,
  input  logic                     dstrm_crc_valid,
  input  logic                     dstrm_valid,
  // upstream channel to the adapter
  output logic [lpif_state_w-1:0]  ustrm_state,
  output logic [lpif_protid_w-1:0] ustrm_protid,
  output logic [lpif_data_w-1:0]   ustrm_data,
  output logic                     ustrm_dvalid,
  output logic [lpif_crc_w-1:0]    ustrm_crc,
  output logic                     ustrm_crc_valid,
  output logic                     ustrm_valid,
  // physical link side
  output logic [lpif_word_w-1:0]   link_tx_data,
  output logic                     link_tx_valid,
  input  logic                     link_hold,
  input  logic [lpif_word_w-1:0]   link_rx_data,
  input  logic                     link_rx_valid,
  // register port
  input  logic                     cfg_wr,
  input  logic [cfg_addr_w-1:0]    cfg_addr,
  input  logic [cfg_data_w-1:0]    cfg_wdata,
  output logic [cfg_data_w-1:0]    cfg_rdata
);

  logic [lpif_word_w-1:0] tx_word;
  logic [lpif_word_w-1:0] rx_word;
  logic                   rx_valid;
  logic                   fifo_overflow;
  logic                   gen2_mode;
  logic                   loopback;

  ///////////////////////////////
  // receive source select
  ///////////////////////////////

  // loopback turns the transmit fifo output straight back into the receiver
  assign rx_word  = loopback ? link_tx_data : link_rx_data;
  assign rx_valid = loopback ? link_tx_valid : link_rx_valid;

  lpif_flit_packer i_packer (
    .clk             (clk),
    .reset           (reset),
    .gen2_mode       (gen2_mode),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .rx_valid        (rx_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  // every valid downstream flit is queued for the link
  lpif_word_fifo i_tx_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (dstrm_valid),
    .push_data (tx_word),
    .hold      (link_hold),
    .pop_valid (link_tx_valid),
    .pop_data  (link_tx_data),
    .overflow  (fifo_overflow)
  );

  lpif_link_regs i_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .tx_flit   (link_tx_valid),
    .rx_flit   (ustrm_valid),
    .overflow  (fifo_overflow),
    .gen2_mode (gen2_mode),
    .loopback  (loopback)
  );

endmodule

/* logic/lpif_word_fifo.sv */
/*
 * lpif word fifo
 * small circular buffer of link words, drained one per cycle unless held
 */
`timescale 1ns/10ps

module lpif_word_fifo
  import lpif_link_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  logic [lpif_word_w-1:0] push_data,
  input  logic                   hold,
  output logic                   pop_valid,
  output logic [lpif_word_w-1:0] pop_data,
  output logic                   overflow
);

  logic [lpif_word_w-1:0] mem [fifo_depth];
  logic [fifo_ptr_w-1:0]  wr_ptr;
  logic [fifo_ptr_w-1:0]  rd_ptr;
  logic [fifo_cnt_w-1:0]  count;
  logic                   full;
  logic                   pop;
  logic                   do_push;

  assign full = (count == fifo_cnt_w'(fifo_depth));

  // drain whenever something is stored and the link is not holding
  assign pop = (count != '0) && !hold;

  // a full fifo still accepts if a slot frees up this cycle
  assign do_push  = push && (!full || pop);
  assign overflow = push && full && !pop;

  ///////////////////////////////
  // pointers and count
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  ///////////////////////////////
  // registered output
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pop_valid <= 1'b0;
    end else begin
      pop_valid <= pop;
    end
  end

  // old contents are read when a full fifo is written and popped together
  always_ff @(posedge clk) begin
    if (pop) begin
      pop_data <= mem[rd_ptr];
    end
  end

  a_count_bound : assert property (@(posedge clk) disable iff (reset)
    count <= fifo_cnt_w'(fifo_depth));

endmodule

/* lpif_link.f */
logic/lpif_link_pkg.sv
logic/lpif_flit_packer.sv
logic/lpif_word_fifo.sv
logic/lpif_link_regs.sv
logic/lpif_link_top.sv
dv/lpif_link_tb.sv

/* run.sh */
#!/bin/sh
# build and run the lpif link testbench with verilator
# the simulator exit status tells pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f lpif_link.f \
  --top-module lpif_link_tb \
  --Mdir obj_dir \
  -o lpif_link_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/lpif_link_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
